// ==== axi_chan_arbiter.sv ====
// address channel arbiter: round-robin pick among inputs, grant held until handshake
`default_nettype none

module axi_chan_arbiter #(
    parameter int unsigned N_INP = 3
) (
    input  wire logic                                clk_i,
    input  wire logic                                rst_n_i,
    input  cache_axi_pkg::ax_chan_t [N_INP-1:0]      inp_chan_i,
    input  wire logic               [N_INP-1:0]      inp_valid_i,
    output logic                    [N_INP-1:0]      inp_ready_o,
    output cache_axi_pkg::ax_chan_t                  oup_chan_o,
    output logic                                     oup_valid_o,
    input  wire logic                                oup_ready_i,
    input  wire logic                                block_i      // hold off new grants
);

    localparam int unsigned IDX_W = (N_INP > 1) ? $clog2(N_INP) : 1;

    typedef logic [IDX_W-1:0] idx_t;

    idx_t rr_q;        // first input to look at
    logic lock_q;      // grant pinned during back-pressure
    idx_t lock_idx_q;

    idx_t pick_idx;
    logic pick_found;
    idx_t grant_idx;
    logic grant_valid;
    logic handshake;

    // ----------------------------------------
    // round-robin search from the pointer
    // ----------------------------------------
    always_comb begin : rr_pick
        int idx;
        pick_found = 1'b0;
        pick_idx   = rr_q;
        for (int i = 0; i < int'(N_INP); i++) begin
            idx = (int'(rr_q) + i) % int'(N_INP);
            if (!pick_found && inp_valid_i[idx]) begin
                pick_found = 1'b1;
                pick_idx   = idx_t'(idx);
            end
        end
    end

    assign grant_idx   = lock_q ? lock_idx_q : pick_idx;
    assign grant_valid = lock_q ? inp_valid_i[lock_idx_q] : pick_found;

    assign oup_valid_o = grant_valid & ~block_i;
    assign oup_chan_o  = inp_chan_i[grant_idx];
    assign handshake   = oup_valid_o & oup_ready_i;

    // ready only to the granted input
    always_comb begin
        for (int i = 0; i < int'(N_INP); i++) begin
            inp_ready_o[i] = handshake && (grant_idx == idx_t'(i));
        end
    end

    // ----------------------------------------
    // lock and pointer state
    // ----------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rr_q       <= '0;
            lock_q     <= 1'b0;
            lock_idx_q <= '0;
        end else if (handshake) begin
            lock_q <= 1'b0;
            // move past the winner
            if (grant_idx == idx_t'(N_INP - 1)) begin
                rr_q <= '0;
            end else begin
                rr_q <= grant_idx + idx_t'(1);
            end
        end else if (oup_valid_o) begin
            lock_q     <= 1'b1;  // waiting on ready
            lock_idx_q <= grant_idx;
        end
    end

endmodule

`default_nettype wire

// ==== cache_axi_pkg.sv ====
// cache AXI package: channel structs, request/response bundles and the master ID map
`default_nettype none

package cache_axi_pkg;

    // ----------------------------------------
    // widths and scalar types
    // ----------------------------------------
    localparam int unsigned N_MST  = 3;  // icache, bypass, dcache
    localparam int unsigned ID_W   = 4;
    localparam int unsigned ADDR_W = 32;
    localparam int unsigned DATA_W = 64;

    typedef logic [ID_W-1:0]     id_t;
    typedef logic [ADDR_W-1:0]   addr_t;
    typedef logic [DATA_W-1:0]   data_t;
    typedef logic [DATA_W/8-1:0] strb_t;

    // ----------------------------------------
    // master indices and ID map
    // ----------------------------------------
    typedef logic [1:0] mst_idx_t;

    localparam mst_idx_t MST_DCACHE = 2'd0;  // refill and writeback
    localparam mst_idx_t MST_BYPASS = 2'd1;  // uncached accesses
    localparam mst_idx_t MST_ICACHE = 2'd2;

    localparam id_t        ID_ICACHE        = 4'b0000;
    localparam logic [1:0] ID_BYPASS_PREFIX = 2'b10;  // 10xx, low bits free
    localparam id_t        ID_DCACHE        = 4'b1100;

    // ----------------------------------------
    // channel payloads
    // ----------------------------------------
    typedef struct packed {
        id_t        id;
        addr_t      addr;
        logic [7:0] len;   // beats minus one
        logic [2:0] size;
    } ax_chan_t;           // shared by AR and AW

    typedef struct packed {
        data_t data;
        strb_t strb;
        logic  last;
    } w_chan_t;

    typedef struct packed {
        id_t        id;
        data_t      data;
        logic [1:0] resp;
        logic       last;
    } r_chan_t;

    typedef struct packed {
        id_t        id;
        logic [1:0] resp;
    } b_chan_t;

    // master to slave bundle
    typedef struct packed {
        ax_chan_t ar;
        logic     ar_valid;
        ax_chan_t aw;
        logic     aw_valid;
        w_chan_t  w;
        logic     w_valid;
        logic     r_ready;
        logic     b_ready;
    } axi_req_t;

    // slave to master bundle
    typedef struct packed {
        logic    ar_ready;
        logic    aw_ready;
        logic    w_ready;
        r_chan_t r;
        logic    r_valid;
        b_chan_t b;
        logic    b_valid;
    } axi_rsp_t;

    // owner of a transaction ID, unknown IDs fall to the data cache
    function automatic mst_idx_t id_to_mst(id_t id);
        mst_idx_t mst;
        case (id)
            ID_ICACHE: mst = MST_ICACHE;
            ID_DCACHE: mst = MST_DCACHE;
            default: begin
                if (id[ID_W-1 -: 2] == ID_BYPASS_PREFIX) begin
                    mst = MST_BYPASS;
                end else begin
                    mst = MST_DCACHE;
                end
            end
        endcase
        return mst;
    endfunction

endpackage

`default_nettype wire

// ==== cache_mem_mux.sv ====
// cache memory port mux: joins icache, bypass and dcache AXI masters onto one memory port
`default_nettype none

module cache_mem_mux #(
    parameter int unsigned W_FIFO_DEPTH = 4
) (
    input  wire logic                                        clk_i,
    input  wire logic                                        rst_n_i,
    input  cache_axi_pkg::axi_req_t [cache_axi_pkg::N_MST-1:0] mst_req_i,
    output cache_axi_pkg::axi_rsp_t [cache_axi_pkg::N_MST-1:0] mst_rsp_o,
    output cache_axi_pkg::axi_req_t                          mem_req_o,
    input  cache_axi_pkg::axi_rsp_t                          mem_rsp_i
);

    localparam int unsigned N_MST = cache_axi_pkg::N_MST;

    // per-master views of the address channels
    cache_axi_pkg::ax_chan_t [N_MST-1:0] ar_chan;
    cache_axi_pkg::ax_chan_t [N_MST-1:0] aw_chan;
    logic [N_MST-1:0] ar_valid;
    logic [N_MST-1:0] aw_valid;
    logic [N_MST-1:0] ar_ready;
    logic [N_MST-1:0] aw_ready;

    cache_axi_pkg::ax_chan_t ar_out;
    cache_axi_pkg::ax_chan_t aw_out;
    logic ar_out_valid;
    logic aw_out_valid;

    // W routing
    logic                    w_full;
    logic                    w_sel_valid;
    cache_axi_pkg::mst_idx_t w_sel;
    logic                    w_out_valid;
    logic                    aw_fire;
    logic                    w_last_fire;

    // response routing
    logic [N_MST-1:0] r_valid;
    logic [N_MST-1:0] b_valid;
    logic [N_MST-1:0] r_ready;
    logic [N_MST-1:0] b_ready;
    logic             r_ready_out;
    logic             b_ready_out;

    always_comb begin
        for (int m = 0; m < int'(N_MST); m++) begin
            ar_chan[m]  = mst_req_i[m].ar;
            ar_valid[m] = mst_req_i[m].ar_valid;
            aw_chan[m]  = mst_req_i[m].aw;
            aw_valid[m] = mst_req_i[m].aw_valid;
            r_ready[m]  = mst_req_i[m].r_ready;
            b_ready[m]  = mst_req_i[m].b_ready;
        end
    end

    // ----------------------------------------
    // AR and AW arbitration
    // ----------------------------------------
    axi_chan_arbiter #(
        .N_INP       ( N_MST        )
    ) u_ar_arb (
        .clk_i       ( clk_i        ),
        .rst_n_i     ( rst_n_i      ),
        .inp_chan_i  ( ar_chan      ),
        .inp_valid_i ( ar_valid     ),
        .inp_ready_o ( ar_ready     ),
        .oup_chan_o  ( ar_out       ),
        .oup_valid_o ( ar_out_valid ),
        .oup_ready_i ( mem_rsp_i.ar_ready ),
        .block_i     ( 1'b0         )  // reads need no ordering record
    );

    axi_chan_arbiter #(
        .N_INP       ( N_MST        )
    ) u_aw_arb (
        .clk_i       ( clk_i        ),
        .rst_n_i     ( rst_n_i      ),
        .inp_chan_i  ( aw_chan      ),
        .inp_valid_i ( aw_valid     ),
        .inp_ready_o ( aw_ready     ),
        .oup_chan_o  ( aw_out       ),
        .oup_valid_o ( aw_out_valid ),
        .oup_ready_i ( mem_rsp_i.aw_ready ),
        .block_i     ( w_full       )  // no room to record the owner
    );

    // ----------------------------------------
    // W ordering, AXI4 carries no WID
    // ----------------------------------------
    assign aw_fire     = aw_out_valid & mem_rsp_i.aw_ready;
    assign w_out_valid = w_sel_valid & mst_req_i[w_sel].w_valid;
    assign w_last_fire = w_out_valid & mem_rsp_i.w_ready & mst_req_i[w_sel].w.last;

    w_route_fifo #(
        .W_FIFO_DEPTH  ( W_FIFO_DEPTH )
    ) u_w_route (
        .clk_i         ( clk_i        ),
        .rst_n_i       ( rst_n_i      ),
        .aw_id_i       ( aw_out.id    ),
        .aw_fire_i     ( aw_fire      ),
        .w_last_fire_i ( w_last_fire  ),
        .full_o        ( w_full       ),
        .sel_valid_o   ( w_sel_valid  ),
        .sel_o         ( w_sel        )
    );

    // ----------------------------------------
    // R and B steering by ID
    // ----------------------------------------
    resp_id_router u_r_route (
        .id_i        ( mem_rsp_i.r.id    ),
        .inp_valid_i ( mem_rsp_i.r_valid ),
        .inp_ready_o ( r_ready_out       ),
        .oup_valid_o ( r_valid           ),
        .oup_ready_i ( r_ready           )
    );

    resp_id_router u_b_route (
        .id_i        ( mem_rsp_i.b.id    ),
        .inp_valid_i ( mem_rsp_i.b_valid ),
        .inp_ready_o ( b_ready_out       ),
        .oup_valid_o ( b_valid           ),
        .oup_ready_i ( b_ready           )
    );

    // memory side bundle
    always_comb begin
        mem_req_o.ar       = ar_out;
        mem_req_o.ar_valid = ar_out_valid;
        mem_req_o.aw       = aw_out;
        mem_req_o.aw_valid = aw_out_valid;
        mem_req_o.w        = mst_req_i[w_sel].w;  // head of queue only
        mem_req_o.w_valid  = w_out_valid;
        mem_req_o.r_ready  = r_ready_out;
        mem_req_o.b_ready  = b_ready_out;
    end

    // cache side bundles, payloads broadcast
    always_comb begin
        for (int m = 0; m < int'(N_MST); m++) begin
            mst_rsp_o[m].ar_ready = ar_ready[m];
            mst_rsp_o[m].aw_ready = aw_ready[m];
            mst_rsp_o[m].w_ready  = w_sel_valid && (w_sel == cache_axi_pkg::mst_idx_t'(m))
                                    && mem_rsp_i.w_ready;
            mst_rsp_o[m].r        = mem_rsp_i.r;
            mst_rsp_o[m].r_valid  = r_valid[m];
            mst_rsp_o[m].b        = mem_rsp_i.b;
            mst_rsp_o[m].b_valid  = b_valid[m];
        end
    end

endmodule

`default_nettype wire

// ==== resp_id_router.sv ====
// response router: steers one R or B handshake to the master named by the ID
`default_nettype none

module resp_id_router (
    input  cache_axi_pkg::id_t               id_i,
    input  wire logic                        inp_valid_i,
    output logic                             inp_ready_o,
    output logic [cache_axi_pkg::N_MST-1:0]  oup_valid_o,
    input  wire logic [cache_axi_pkg::N_MST-1:0] oup_ready_i
);

    cache_axi_pkg::mst_idx_t sel;

    // 0000 icache, 10xx bypass, 1100 and the rest dcache
    assign sel = cache_axi_pkg::id_to_mst(id_i);

    // ----------------------------------------
    // valid out to one master only
    // ----------------------------------------
    always_comb begin
        for (int m = 0; m < int'(cache_axi_pkg::N_MST); m++) begin
            oup_valid_o[m] = inp_valid_i && (sel == cache_axi_pkg::mst_idx_t'(m));
        end
    end

    // ready back from the selected master
    always_comb begin
        inp_ready_o = 1'b0;
        for (int m = 0; m < int'(cache_axi_pkg::N_MST); m++) begin
            if (sel == cache_axi_pkg::mst_idx_t'(m)) begin
                inp_ready_o = oup_ready_i[m];
            end
        end
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# compile and run the cache memory mux testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_cache_mem_mux \
    -f src.f \
    --Mdir obj_dir \
    -o sim_tb

./obj_dir/sim_tb

// ==== src.f ====
cache_axi_pkg.sv
axi_chan_arbiter.sv
w_route_fifo.sv
resp_id_router.sv
cache_mem_mux.sv
tb_mem_slave.sv
tb_cache_mem_mux.sv

// ==== tb_cache_mem_mux.sv ====
// testbench for the cache memory port mux with three cache masters and one memory slave
`default_nettype none

module tb_cache_mem_mux;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int unsigned TIMEOUT_CYCLES = 4000;  // about 20x the test length

    logic clk;
    logic rst_n;
    logic first_cycle_q;
    int unsigned cycles;

    cache_axi_pkg::axi_req_t [2:0] mst_req;
    cache_axi_pkg::axi_rsp_t [2:0] mst_rsp;
    cache_axi_pkg::axi_req_t       mem_req;
    cache_axi_pkg::axi_rsp_t       mem_rsp;
    logic [2:0]                    mst_done;

    logic [1:0] wq[$];      // expected W owners in AW order
    logic [1:0] exp_w_own;
    logic       exp_w_pend;
    logic [1:0] r_own;
    logic [1:0] b_own;
    logic       up_ready_any;

    // 0000 is the icache, 10xx the bypass and anything else the dcache
    function automatic logic [1:0] owner_of_id(input logic [3:0] id);
        if (id == 4'b0000) return 2'd2;
        if (id[3:2] == 2'b10) return 2'd1;
        return 2'd0;
    endfunction

    function automatic logic [3:0] id_of_master(input int m);
        return (m == 2) ? 4'b0000 : (m == 1) ? 4'b1001 : 4'b1100;
    endfunction

    // master index in the top byte and beat in the low byte
    function automatic logic [63:0] w_word(input int m, input logic [7:0] beat);
        return {8'(m), 48'h0000_a5a5_0000, beat};
    endfunction

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1);
    endtask

    cache_mem_mux #(
        .W_FIFO_DEPTH ( 4       )
    ) u_dut (
        .clk_i        ( clk     ),
        .rst_n_i      ( rst_n   ),
        .mst_req_i    ( mst_req ),
        .mst_rsp_o    ( mst_rsp ),
        .mem_req_o    ( mem_req ),
        .mem_rsp_i    ( mem_rsp )
    );

    tb_mem_slave u_mem (
        .clk_i   ( clk     ),
        .rst_n_i ( rst_n   ),
        .req_i   ( mem_req ),
        .rsp_o   ( mem_rsp )
    );

    // ----------------------------------------
    // clock, reset, timeout
    // ----------------------------------------
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) first_cycle_q <= 1'b1;
        else first_cycle_q <= 1'b0;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) stop_run("Timeout: masters did not finish in time");
    end

    initial begin
        rst_n  = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        wait (&mst_done);
        repeat (4) @(posedge clk);
        $display("Regression passed");
        $finish;
    end

    // ----------------------------------------
    // cache masters
    // ----------------------------------------
    for (genvar m = 0; m < 3; m++) begin : g_mst
        cache_axi_pkg::axi_req_t req;
        logic   fin;
        integer seed;

        assign mst_req[m]  = req;
        assign mst_done[m] = fin;

        task automatic gap();
            repeat ($unsigned($random(seed)) % 3) begin
                @(posedge clk);
                #1;
            end
        endtask

        task automatic write_burst(input logic [31:0] addr, input logic [7:0] len);
            logic [7:0] beat;
            logic aw_hs;
            logic w_hs;
            logic done;
            beat = '0;
            done = 1'b0;
            req.aw.id = id_of_master(m);
            req.aw.addr = addr;
            req.aw.len = len;
            req.aw.size = 3'd3;
            req.aw_valid = 1'b1;
            req.w.data = w_word(m, beat);  // W offered before its AW is taken
            req.w.strb = '1;
            req.w.last = (beat == len);
            req.w_valid = 1'b1;
            while (!done) begin
                @(negedge clk);
                aw_hs = req.aw_valid && mst_rsp[m].aw_ready;
                w_hs  = req.w_valid && mst_rsp[m].w_ready;
                done  = mst_rsp[m].b_valid && req.b_ready;
                @(posedge clk);
                #1;
                if (aw_hs) req.aw_valid = 1'b0;
                if (w_hs && beat == len) begin
                    req.w_valid = 1'b0;
                end else if (w_hs) begin
                    beat = beat + 8'd1;
                    req.w.data = w_word(m, beat);
                    req.w.last = (beat == len);
                end
                req.b_ready = (($random(seed) & 3) != 0);
            end
            req.b_ready = 1'b0;
        endtask

        task automatic read_burst(input logic [31:0] addr, input logic [7:0] len);
            logic ar_hs;
            logic done;
            done = 1'b0;
            req.ar.id = id_of_master(m);
            req.ar.addr = addr;
            req.ar.len = len;
            req.ar.size = 3'd3;
            req.ar_valid = 1'b1;
            while (!done) begin
                @(negedge clk);
                ar_hs = req.ar_valid && mst_rsp[m].ar_ready;
                done  = mst_rsp[m].r_valid && req.r_ready && mst_rsp[m].r.last;
                @(posedge clk);
                #1;
                if (ar_hs) req.ar_valid = 1'b0;
                req.r_ready = (($random(seed) & 3) != 0);
            end
            req.r_ready = 1'b0;
        endtask

        initial begin
            logic [31:0] addr;
            seed = 32'h490ee6ba + m;  // one stream per master
            req  = '0;
            fin  = 1'b0;
            wait (rst_n);
            repeat (2) @(posedge clk);
            #1;
            for (int r = 0; r < 4; r++) begin
                addr = 32'h8000_0000 | (m << 12) | (r << 6);
                write_burst(addr, 8'((m + r) % 4));
                gap();
                read_burst(addr, 8'((m + 2 * r) % 4));
                gap();
            end
            fin = 1'b1;
        end
    end

    // ----------------------------------------
    // reference models
    // ----------------------------------------
    always @(posedge clk) begin
        if (rst_n) begin
            if (mem_req.w_valid && mem_rsp.w_ready && mem_req.w.last && wq.size() != 0) begin
                void'(wq.pop_front());
            end
            if (mem_req.aw_valid && mem_rsp.aw_ready) wq.push_back(owner_of_id(mem_req.aw.id));
            exp_w_pend <= (wq.size() != 0);
            exp_w_own  <= (wq.size() != 0) ? wq[0] : 2'd0;
        end else begin
            exp_w_pend <= 1'b0;
            exp_w_own  <= 2'd0;
        end
    end

    always_comb begin
        r_own = owner_of_id(mem_rsp.r.id);
        b_own = owner_of_id(mem_rsp.b.id);
        up_ready_any = 1'b0;
        for (int m = 0; m < 3; m++) begin
            up_ready_any |= mst_rsp[m].ar_ready | mst_rsp[m].aw_ready | mst_rsp[m].w_ready;
        end
    end

    // ----------------------------------------
    // checks
    // ----------------------------------------
    a_reset: assert property (@(posedge clk) (!rst_n || first_cycle_q) |->
            !mem_req.ar_valid && !mem_req.aw_valid && !mem_req.w_valid && !up_ready_any)
        else stop_run($sformatf("MISMATCH %0t: valid or ready high around reset", $time));

    a_addr_hold: assert property (@(posedge clk) disable iff (!rst_n)
            (mem_req.ar_valid && !mem_rsp.ar_ready |=> mem_req.ar_valid && $stable(mem_req.ar))
            and (mem_req.aw_valid && !mem_rsp.aw_ready |=> mem_req.aw_valid && $stable(mem_req.aw)))
        else stop_run($sformatf("MISMATCH %0t: address payload moved under back-pressure", $time));

    a_w_order: assert property (@(posedge clk) disable iff (!rst_n)
            mem_req.w_valid |-> exp_w_pend && mem_req.w.data[63:56] == 8'(exp_w_own))
        else stop_run($sformatf("MISMATCH %0t: W beat from wrong master", $time));

    a_resp_ready: assert property (@(posedge clk) disable iff (!rst_n)
            mem_req.r_ready == mst_req[r_own].r_ready && mem_req.b_ready == mst_req[b_own].b_ready)
        else stop_run($sformatf("MISMATCH %0t: response ready not from the ID owner", $time));

    for (genvar m = 0; m < 3; m++) begin : g_chk
        int unsigned ar_wait;  // other grants seen while this master waits
        int unsigned aw_wait;

        always @(posedge clk) begin
            if (!rst_n || !mst_req[m].ar_valid || mst_rsp[m].ar_ready) ar_wait <= 0;
            else if (mem_req.ar_valid && mem_rsp.ar_ready) ar_wait <= ar_wait + 1;
            if (!rst_n || !mst_req[m].aw_valid || mst_rsp[m].aw_ready) aw_wait <= 0;
            else if (mem_req.aw_valid && mem_rsp.aw_ready) aw_wait <= aw_wait + 1;
        end

        a_grant: assert property (@(posedge clk) disable iff (!rst_n)
                (mst_rsp[m].ar_ready |-> mem_req.ar == mst_req[m].ar)
                and (mst_rsp[m].aw_ready |-> mem_req.aw == mst_req[m].aw)
                and (ar_wait <= 2 && aw_wait <= 2))
            else stop_run($sformatf("MISMATCH %0t: grant payload or fairness, master %0d",
                                    $time, m));

        a_route: assert property (@(posedge clk) disable iff (!rst_n)
                mst_rsp[m].r_valid == (mem_rsp.r_valid && r_own == 2'(m))
                && mst_rsp[m].b_valid == (mem_rsp.b_valid && b_own == 2'(m))
                && mst_rsp[m].r == mem_rsp.r && mst_rsp[m].b == mem_rsp.b)
            else stop_run($sformatf("MISMATCH %0t: R or B misrouted, master %0d", $time, m));

        a_stall: assert property (@(posedge clk) disable iff (!rst_n)
                (!mem_rsp.ar_ready |-> !mst_rsp[m].ar_ready)
                and (!mem_rsp.aw_ready |-> !mst_rsp[m].aw_ready)
                and (!mem_rsp.w_ready |-> !mst_rsp[m].w_ready))
            else stop_run($sformatf("MISMATCH %0t: ready passed a slave stall, master %0d",
                                    $time, m));
    end

endmodule

`default_nettype wire

// ==== tb_mem_slave.sv ====
// testbench memory slave with random-stall readies, queued bursts and ID-echoing R and B
`default_nettype none

module tb_mem_slave (
    input  wire logic               clk_i,
    input  wire logic               rst_n_i,
    input  cache_axi_pkg::axi_req_t req_i,
    output cache_axi_pkg::axi_rsp_t rsp_o
);
    timeunit 1ns;
    timeprecision 1ps;

    cache_axi_pkg::ax_chan_t rd_q[$];  // accepted reads served in order
    cache_axi_pkg::id_t      aw_q[$];  // writes waiting for their last beat
    cache_axi_pkg::id_t      b_q[$];
    logic [7:0]              rd_beat;
    integer                  seed;

    // read data depends on address and beat
    function automatic cache_axi_pkg::data_t read_word(input cache_axi_pkg::addr_t addr,
                                                       input logic [7:0] beat);
        return {addr, 24'h5e0000, beat};
    endfunction

    initial begin
        cache_axi_pkg::ax_chan_t ar_cap;
        cache_axi_pkg::id_t      aw_id_cap;
        logic ar_fire;
        logic aw_fire;
        logic w_last_fire;
        logic r_fire;
        logic b_fire;
        seed    = 32'h490ee6ba;
        rsp_o   = '0;
        // readies stay up through reset so the mux alone has to hold them off
        rsp_o.ar_ready = 1'b1;
        rsp_o.aw_ready = 1'b1;
        rsp_o.w_ready  = 1'b1;
        rd_beat = '0;
        wait (rst_n_i);
        forever begin
            // handshakes are settled mid-cycle
            @(negedge clk_i);
            ar_fire     = req_i.ar_valid && rsp_o.ar_ready;
            aw_fire     = req_i.aw_valid && rsp_o.aw_ready;
            w_last_fire = req_i.w_valid && rsp_o.w_ready && req_i.w.last;
            r_fire      = rsp_o.r_valid && req_i.r_ready;
            b_fire      = rsp_o.b_valid && req_i.b_ready;
            ar_cap      = req_i.ar;
            aw_id_cap   = req_i.aw.id;
            @(posedge clk_i);
            #1;
            if (r_fire) begin
                if (rsp_o.r.last) begin
                    void'(rd_q.pop_front());
                    rd_beat = '0;
                end else begin
                    rd_beat = rd_beat + 8'd1;
                end
            end
            if (w_last_fire && aw_q.size() != 0) b_q.push_back(aw_q.pop_front());
            if (b_fire) void'(b_q.pop_front());
            if (ar_fire) rd_q.push_back(ar_cap);
            if (aw_fire) aw_q.push_back(aw_id_cap);

            rsp_o.ar_ready = (rd_q.size() < 4) && (($random(seed) & 1) != 0);
            rsp_o.aw_ready = (aw_q.size() < 4) && (($random(seed) & 1) != 0);
            rsp_o.w_ready  = (aw_q.size() != 0) && (($random(seed) & 1) != 0);

            // a raised valid stays up until taken
            if (!(rsp_o.r_valid && !r_fire)) begin
                rsp_o.r_valid = (rd_q.size() != 0) && (($random(seed) & 1) != 0);
            end
            if (rd_q.size() != 0) begin
                rsp_o.r.id   = rd_q[0].id;
                rsp_o.r.data = read_word(rd_q[0].addr, rd_beat);
                rsp_o.r.resp = 2'b00;
                rsp_o.r.last = (rd_beat == rd_q[0].len);
            end
            if (!(rsp_o.b_valid && !b_fire)) begin
                rsp_o.b_valid = (b_q.size() != 0) && (($random(seed) & 1) != 0);
            end
            if (b_q.size() != 0) begin
                rsp_o.b.id   = b_q[0];
                rsp_o.b.resp = 2'b00;  // OKAY
            end
        end
    end

endmodule

`default_nettype wire

// ==== w_route_fifo.sv ====
// W routing queue: records the owner of each accepted AW and selects the W source
`default_nettype none

module w_route_fifo #(
    parameter int unsigned W_FIFO_DEPTH = 4
) (
    input  wire logic                    clk_i,
    input  wire logic                    rst_n_i,
    input  cache_axi_pkg::id_t           aw_id_i,
    input  wire logic                    aw_fire_i,
    input  wire logic                    w_last_fire_i,
    output logic                         full_o,
    output logic                         sel_valid_o,
    output cache_axi_pkg::mst_idx_t      sel_o
);

    localparam int unsigned PTR_W = (W_FIFO_DEPTH > 1) ? $clog2(W_FIFO_DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(W_FIFO_DEPTH + 1);

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [CNT_W-1:0] cnt_t;

    cache_axi_pkg::mst_idx_t owner_mem [W_FIFO_DEPTH];  // owners in AW order
    ptr_t wr_ptr_q;
    ptr_t rd_ptr_q;
    cnt_t count_q;

    cache_axi_pkg::mst_idx_t aw_owner;
    logic push;
    logic pop;

    // owner of the burst just accepted downstream
    assign aw_owner = cache_axi_pkg::id_to_mst(aw_id_i);

    assign full_o      = (count_q == cnt_t'(W_FIFO_DEPTH));
    assign sel_valid_o = (count_q != '0);
    assign sel_o       = owner_mem[rd_ptr_q];

    assign push = aw_fire_i & ~full_o;       // arbiter already holds AW when full
    assign pop  = w_last_fire_i & sel_valid_o;

    // pointer wrap for any depth
    function automatic ptr_t ptr_next(ptr_t ptr);
        ptr_t nxt;
        if (ptr == ptr_t'(W_FIFO_DEPTH - 1)) begin
            nxt = '0;
        end else begin
            nxt = ptr + ptr_t'(1);
        end
        return nxt;
    endfunction

    // ----------------------------------------
    // storage
    // ----------------------------------------
    always_ff @(posedge clk_i) begin
        if (push) begin
            owner_mem[wr_ptr_q] <= aw_owner;
        end
    end

    // ----------------------------------------
    // pointers and fill level
    // ----------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= ptr_next(wr_ptr_q);
            end
            if (pop) begin
                rd_ptr_q <= ptr_next(rd_ptr_q);  // last beat of the head burst
            end
            if (push && !pop) begin
                count_q <= count_q + cnt_t'(1);
            end else if (pop && !push) begin
                count_q <= count_q - cnt_t'(1);
            end
        end
    end

endmodule

`default_nettype wire
